// File: verilog/muldiv_pkg.sv
// -----------------------------------------------
// Shared widths, RISC-V M-extension codes and
// queue and divider constants for muldiv
// -----------------------------------------------
`default_nettype none

package muldiv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int FUNCT3_W   = 3;

    // -----------------------------------------------
    // Instruction encoding
    // -----------------------------------------------
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;  // Register-register major opcode
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;  // Marks the M-extension

    localparam logic [FUNCT3_W-1:0] F3_MUL    = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_MULH   = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_MULHSU = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_MULHU  = 3'b011;
    localparam logic [FUNCT3_W-1:0] F3_DIV    = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_DIVU   = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_REM    = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_REMU   = 3'b111;
    localparam int                  F3_DIV_BIT = 2;  // Set for the divide group

    // -----------------------------------------------
    // Queue and divider
    // -----------------------------------------------
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = 2;
    localparam int DIV_STEPS   = 32;
    localparam int DIV_CNT_W   = 5;

    localparam logic [1:0] DIV_ST_IDLE  = 2'd0;
    localparam logic [1:0] DIV_ST_CHECK = 2'd1;  // Divisor test and magnitudes
    localparam logic [1:0] DIV_ST_EXEC  = 2'd2;  // Shift-subtract steps
    localparam logic [1:0] DIV_ST_RET   = 2'd3;  // Result valid

endpackage

`default_nettype wire

// File: verilog/muldiv_op_if.sv
// -----------------------------------------------
// One decoded M-extension operation passed
// between the decoder, the queue and the sequencer
// -----------------------------------------------
`timescale 1ns/1ns
`default_nettype none

interface muldiv_op_if;

    logic                              valid;   // Strobe or level, per link
    logic [muldiv_pkg::FUNCT3_W-1:0]   funct3;
    logic [muldiv_pkg::REG_ADDR_W-1:0] rd;
    logic [muldiv_pkg::XLEN-1:0]       src1;
    logic [muldiv_pkg::XLEN-1:0]       src2;

    modport src (output valid, output funct3, output rd, output src1, output src2);
    modport dst (input valid, input funct3, input rd, input src1, input src2);

endinterface

`default_nettype wire

// File: verilog/muldiv_decode.sv
// -----------------------------------------------
// Request decoder: registers each strobed word,
// pushes M-extension operations, flags the rest
// -----------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module muldiv_decode (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        req_valid_i,
    input  logic [muldiv_pkg::XLEN-1:0] req_ir_i,
    input  logic [muldiv_pkg::XLEN-1:0] req_src1_i,
    input  logic [muldiv_pkg::XLEN-1:0] req_src2_i,
    output logic                        illegal_o,
    muldiv_op_if.src                    push_o
);
    import muldiv_pkg::*;

    logic is_muldiv;

    // OP major opcode with the M-extension funct7
    assign is_muldiv = (req_ir_i[6:0] == OPCODE_OP) && (req_ir_i[31:25] == FUNCT7_MULDIV);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            push_o.valid <= 1'b0;
            illegal_o    <= 1'b0;
        end else begin
            push_o.valid <= req_valid_i & is_muldiv;   // One-cycle push
            illegal_o    <= req_valid_i & ~is_muldiv;  // One-cycle reject
        end
    end

    // Operation fields, only meaningful with push_o.valid
    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            push_o.funct3 <= req_ir_i[14:12];
            push_o.rd     <= req_ir_i[11:7];
            push_o.src1   <= req_src1_i;
            push_o.src2   <= req_src2_i;
        end
    end

endmodule

`default_nettype wire

// File: verilog/muldiv_queue.sv
// -----------------------------------------------
// Circular request FIFO between decoder and
// sequencer, with a sticky overflow flag
// -----------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module muldiv_queue (
    input  logic      clk_i,
    input  logic      rst_i,
    muldiv_op_if.dst  push_i,
    muldiv_op_if.src  head_o,
    input  logic      pop_i,
    output logic      overflow_o
);
    import muldiv_pkg::*;

    logic [FUNCT3_W-1:0]   funct3_mem [QUEUE_DEPTH];
    logic [REG_ADDR_W-1:0] rd_mem     [QUEUE_DEPTH];
    logic [XLEN-1:0]       src1_mem   [QUEUE_DEPTH];
    logic [XLEN-1:0]       src2_mem   [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_PTR_W:0]   count;
    logic                   full;
    logic                   do_push;
    logic                   do_pop;
    logic                   drop;

    assign full    = (count == (QUEUE_PTR_W+1)'(QUEUE_DEPTH));
    assign do_pop  = pop_i & (count != '0);
    assign do_push = push_i.valid & (~full | do_pop);  // Full queue frees a slot on pop
    assign drop    = push_i.valid & full & ~do_pop;

    // Head entry shown continuously
    assign head_o.valid  = (count != '0);
    assign head_o.funct3 = funct3_mem[rd_ptr];
    assign head_o.rd     = rd_mem[rd_ptr];
    assign head_o.src1   = src1_mem[rd_ptr];
    assign head_o.src2   = src2_mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            funct3_mem[wr_ptr] <= push_i.funct3;
            rd_mem[wr_ptr]     <= push_i.rd;
            src1_mem[wr_ptr]   <= push_i.src1;
            src2_mem[wr_ptr]   <= push_i.src2;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;  // Wraps at QUEUE_DEPTH
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (drop) overflow_o <= 1'b1;  // Held until reset
        end
    end

endmodule

`default_nettype wire

// File: verilog/mul_unit.sv
// -----------------------------------------------
// Two-stage multiplier for MUL, MULH, MULHSU and
// MULHU, done two cycles after start
// -----------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module mul_unit (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            start_i,
    input  logic [muldiv_pkg::FUNCT3_W-1:0] funct3_i,
    input  logic [muldiv_pkg::XLEN-1:0]     src1_i,
    input  logic [muldiv_pkg::XLEN-1:0]     src2_i,
    output logic                            done_o,
    output logic [muldiv_pkg::XLEN-1:0]     rslt_o
);
    import muldiv_pkg::*;

    logic                     src1_signed;
    logic                     src2_signed;
    logic signed [XLEN:0]     op_a;       // 33-bit extended operands
    logic signed [XLEN:0]     op_b;
    logic signed [2*XLEN+1:0] full_prod;
    logic [2*XLEN-1:0]        prod;
    logic                     is_high;
    logic                     stage1_v;
    logic                     stage2_v;

    always_comb begin
        src1_signed = 1'b0;  // MUL and MULHU
        src2_signed = 1'b0;
        case (funct3_i)
            F3_MULH: begin
                src1_signed = 1'b1;
                src2_signed = 1'b1;
            end
            F3_MULHSU: src1_signed = 1'b1;
            default: ;
        endcase
    end

    assign full_prod = op_a * op_b;

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            op_a    <= {src1_signed & src1_i[XLEN-1], src1_i};
            op_b    <= {src2_signed & src2_i[XLEN-1], src2_i};
            is_high <= (funct3_i != F3_MUL);
        end
        if (stage1_v) prod <= full_prod[2*XLEN-1:0];
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            stage1_v <= 1'b0;
            stage2_v <= 1'b0;
        end else begin
            stage1_v <= start_i;
            stage2_v <= stage1_v;
        end
    end

    assign done_o = stage2_v;
    assign rslt_o = is_high ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];

endmodule

`default_nettype wire

// File: verilog/div_unit.sv
// -----------------------------------------------
// Restoring divider, one quotient bit per cycle,
// with sign fix-up and a divide-by-zero shortcut
// -----------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module div_unit (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            start_i,
    input  logic [muldiv_pkg::FUNCT3_W-1:0] funct3_i,
    input  logic [muldiv_pkg::XLEN-1:0]     src1_i,
    input  logic [muldiv_pkg::XLEN-1:0]     src2_i,
    output logic                            done_o,
    output logic [muldiv_pkg::XLEN-1:0]     rslt_o
);
    import muldiv_pkg::*;

    logic [1:0]           state;
    logic [DIV_CNT_W-1:0] cnt;
    logic [XLEN-1:0]      remainder;  // Holds the raw dividend until CHECK
    logic [XLEN-1:0]      quotient;
    logic [XLEN-1:0]      divisor;
    logic                 is_signed;
    logic                 is_rem;
    logic                 dividend_neg;  // Also the remainder sign
    logic                 divisor_neg;
    logic                 quot_neg;
    logic [XLEN:0]        shifted;
    logic [XLEN:0]        diff;
    logic                 q_bit;

    assign is_signed = (funct3_i == F3_DIV) || (funct3_i == F3_REM);

    // -----------------------------------------------
    // One shift-subtract step
    // -----------------------------------------------
    assign shifted = {remainder, quotient[XLEN-1]};
    assign diff    = shifted - {1'b0, divisor};
    assign q_bit   = ~diff[XLEN];  // No borrow, divisor fits

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= DIV_ST_IDLE;
        end else begin
            case (state)
                DIV_ST_IDLE:  if (start_i) state <= DIV_ST_CHECK;
                DIV_ST_CHECK: state <= (divisor == '0) ? DIV_ST_RET : DIV_ST_EXEC;
                DIV_ST_EXEC:  if (cnt == '0) state <= DIV_ST_RET;
                default:      state <= DIV_ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == DIV_ST_IDLE && start_i) begin
            remainder    <= src1_i;
            divisor      <= src2_i;
            is_rem       <= (funct3_i == F3_REM) || (funct3_i == F3_REMU);
            dividend_neg <= is_signed & src1_i[XLEN-1];
            divisor_neg  <= is_signed & src2_i[XLEN-1];
            quot_neg     <= is_signed & (src1_i[XLEN-1] ^ src2_i[XLEN-1]);
        end else if (state == DIV_ST_CHECK) begin
            if (divisor == '0) begin
                quotient     <= '1;    // All ones, remainder keeps the dividend
                quot_neg     <= 1'b0;
                dividend_neg <= 1'b0;
            end else begin
                remainder <= '0;
                quotient  <= dividend_neg ? -remainder : remainder;
                divisor   <= divisor_neg ? -divisor : divisor;
            end
            cnt <= DIV_CNT_W'(DIV_STEPS - 1);
        end else if (state == DIV_ST_EXEC) begin
            remainder <= q_bit ? diff[XLEN-1:0] : shifted[XLEN-1:0];
            quotient  <= {quotient[XLEN-2:0], q_bit};
            cnt       <= cnt - 1'b1;
        end
    end

    // Most negative by -1 falls out as 0x80000000, remainder 0
    always_comb begin
        if (is_rem) begin
            rslt_o = dividend_neg ? -remainder : remainder;
        end else begin
            rslt_o = quot_neg ? -quotient : quotient;
        end
    end

    assign done_o = (state == DIV_ST_RET);

endmodule

`default_nettype wire

// File: verilog/muldiv_exec.sv
// -----------------------------------------------
// Execution sequencer: pops one queued operation,
// runs it on the multiplier or the divider and
// returns the registered response
// -----------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module muldiv_exec (
    input  logic                              clk_i,
    input  logic                              rst_i,
    muldiv_op_if.dst                          head_i,
    output logic                              pop_o,
    output logic                              resp_valid_o,
    output logic [muldiv_pkg::REG_ADDR_W-1:0] resp_rd_o,
    output logic [muldiv_pkg::XLEN-1:0]       resp_rslt_o
);
    import muldiv_pkg::*;

    logic                  busy;
    logic                  mul_start;
    logic                  div_start;
    logic                  mul_done;
    logic                  div_done;
    logic                  unit_done;
    logic [XLEN-1:0]       mul_rslt;
    logic [XLEN-1:0]       div_rslt;
    logic [REG_ADDR_W-1:0] rd_q;  // Destination of the operation in flight

    assign pop_o     = head_i.valid & ~busy;
    assign div_start = pop_o & head_i.funct3[F3_DIV_BIT];
    assign mul_start = pop_o & ~head_i.funct3[F3_DIV_BIT];
    assign unit_done = mul_done | div_done;

    mul_unit mul_unit_inst (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .start_i  (mul_start),
        .funct3_i (head_i.funct3),
        .src1_i   (head_i.src1),
        .src2_i   (head_i.src2),
        .done_o   (mul_done),
        .rslt_o   (mul_rslt)
    );

    div_unit div_unit_inst (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .start_i  (div_start),
        .funct3_i (head_i.funct3),
        .src1_i   (head_i.src1),
        .src2_i   (head_i.src2),
        .done_o   (div_done),
        .rslt_o   (div_rslt)
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy         <= 1'b0;
            resp_valid_o <= 1'b0;
        end else begin
            if (pop_o) busy <= 1'b1;
            else if (unit_done) busy <= 1'b0;  // Next pop one cycle later
            resp_valid_o <= unit_done;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) rd_q <= head_i.rd;
        if (unit_done) begin
            resp_rd_o   <= rd_q;
            resp_rslt_o <= mul_done ? mul_rslt : div_rslt;
        end
    end

endmodule

`default_nettype wire

// File: verilog/muldiv_top.sv
// -----------------------------------------------
// M-extension execution block top level
// -----------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module muldiv_top (
    input  logic                              clk_i,
    input  logic                              rst_i,
    input  logic                              req_valid_i,
    input  logic [muldiv_pkg::XLEN-1:0]       req_ir_i,
    input  logic [muldiv_pkg::XLEN-1:0]       req_src1_i,
    input  logic [muldiv_pkg::XLEN-1:0]       req_src2_i,
    output logic                              illegal_o,
    output logic                              overflow_o,
    output logic                              resp_valid_o,
    output logic [muldiv_pkg::REG_ADDR_W-1:0] resp_rd_o,
    output logic [muldiv_pkg::XLEN-1:0]       resp_rslt_o
);

    logic pop;  // Sequencer takes the queue head

    muldiv_op_if push_if ();
    muldiv_op_if head_if ();

    muldiv_decode decode_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_ir_i    (req_ir_i),
        .req_src1_i  (req_src1_i),
        .req_src2_i  (req_src2_i),
        .illegal_o   (illegal_o),
        .push_o      (push_if)
    );

    muldiv_queue queue_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .push_i     (push_if),
        .head_o     (head_if),
        .pop_i      (pop),
        .overflow_o (overflow_o)
    );

    muldiv_exec exec_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .head_i       (head_if),
        .pop_o        (pop),
        .resp_valid_o (resp_valid_o),
        .resp_rd_o    (resp_rd_o),
        .resp_rslt_o  (resp_rslt_o)
    );

endmodule

`default_nettype wire

// File: dv/muldiv_tb_asserts.sv
// ------------------------------------------------
// Concurrent checks on the muldiv top level:
// reset, sticky overflow and queue handshakes
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module muldiv_tb_asserts (
    input logic clk_i,
    input logic rst_i,
    input logic resp_valid_i,
    input logic overflow_i,
    input logic illegal_i,
    input logic push_valid_i,
    input logic pop_i,
    input logic head_valid_i
);

    resp_low_in_reset: assert property (@(posedge clk_i) rst_i |=> !resp_valid_i)
        else $error("resp_valid_o high while reset is applied");

    // Overflow is sticky until reset
    overflow_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
        overflow_i |=> overflow_i)
        else $error("overflow_o fell without reset");

    illegal_or_push: assert property (@(posedge clk_i) disable iff (rst_i)
        !(illegal_i && push_valid_i))
        else $error("illegal_o and a queue push for the same request");

    pop_needs_head: assert property (@(posedge clk_i) disable iff (rst_i)
        pop_i |-> head_valid_i)
        else $error("Queue pop while the head entry is invalid");

endmodule

bind muldiv_top muldiv_tb_asserts asserts_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .resp_valid_i (resp_valid_o),
    .overflow_i   (overflow_o),
    .illegal_i    (illegal_o),
    .push_valid_i (push_if.valid),  // Decoder push strobe
    .pop_i        (pop),
    .head_valid_i (head_if.valid)
);

`default_nettype wire

// File: dv/muldiv_tb.sv
// ------------------------------------------------
// Testbench for muldiv that checks multiply, divide,
// ordering, overflow and illegal words against a reference
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module muldiv_tb;
    import muldiv_pkg::*;

    logic                  clk;
    logic                  rst;
    logic                  req_valid;
    logic [XLEN-1:0]       req_ir;
    logic [XLEN-1:0]       req_src1;
    logic [XLEN-1:0]       req_src2;
    logic                  illegal;
    logic                  overflow;
    logic                  resp_valid;
    logic [REG_ADDR_W-1:0] resp_rd;
    logic [XLEN-1:0]       resp_rslt;

    int                    errors;
    int                    checks;
    int                    resp_count;
    int                    illegal_count;
    int                    test_errors;
    integer                seed;
    logic [REG_ADDR_W-1:0] exp_rd_q [$];  // Expected responses in request order
    logic [XLEN-1:0]       exp_rslt_q [$];
    logic [XLEN-1:0]       corners [4];

    muldiv_top muldiv_top_inst (
        .clk_i        (clk),
        .rst_i        (rst),
        .req_valid_i  (req_valid),
        .req_ir_i     (req_ir),
        .req_src1_i   (req_src1),
        .req_src2_i   (req_src2),
        .illegal_o    (illegal),
        .overflow_o   (overflow),
        .resp_valid_o (resp_valid),
        .resp_rd_o    (resp_rd),
        .resp_rslt_o  (resp_rslt)
    );

    always #50 clk = ~clk;  // 100 ns period

    // ------------------------------------------------
    // Reference model of the RISC-V M operations
    // ------------------------------------------------
    function automatic logic [XLEN-1:0] ref_result(input logic [2:0] f3,
                                                   input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
        logic [63:0]        ext_a;
        logic [63:0]        ext_b;
        logic [63:0]        prod;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic [31:0]        r;
        sa = a;
        sb = b;
        ext_a = (f3 == F3_MULH || f3 == F3_MULHSU) ? {{32{a[31]}}, a} : {32'd0, a};
        ext_b = (f3 == F3_MULH) ? {{32{b[31]}}, b} : {32'd0, b};
        prod = ext_a * ext_b;  // True product fits in 64 bits for every variant
        case (f3)
            F3_MUL: r = prod[31:0];
            F3_MULH, F3_MULHSU, F3_MULHU: r = prod[63:32];
            F3_DIV, F3_REM: begin
                if (b == '0) r = (f3 == F3_DIV) ? '1 : a;
                else if (a == 32'h8000_0000 && b == '1) r = (f3 == F3_DIV) ? a : '0;
                else if (f3 == F3_DIV) r = sa / sb;  // Truncates toward zero
                else r = sa % sb;                    // Sign of the dividend
            end
            default: begin
                if (b == '0) r = (f3 == F3_DIVU) ? '1 : a;
                else if (f3 == F3_DIVU) r = a / b;
                else r = a % b;
            end
        endcase
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Drives one request for one cycle from a falling edge
    task automatic send_op(input logic [2:0] f3, input logic [4:0] rd,
                           input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        req_valid = 1'b1;
        req_ir    = {FUNCT7_MULDIV, 5'd2, 5'd1, f3, rd, OPCODE_OP};
        req_src1  = a;
        req_src2  = b;
        exp_rd_q.push_back(rd);
        exp_rslt_q.push_back(ref_result(f3, a, b));
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_drain(input int limit);
        int cycles;
        cycles = 0;
        while (exp_rd_q.size() != 0 && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_rd_q.size() != 0) begin
            $display("Timed out after %0d cycles with %0d responses missing",
                     limit, exp_rd_q.size());
            errors++;
            exp_rd_q.delete();
            exp_rslt_q.delete();
        end
        @(negedge clk);
    endtask

    task automatic wait_illegal(input int target, input int limit);
        int cycles;
        cycles = 0;
        while (illegal_count < target && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (illegal_count < target) begin
            $display("No illegal_o pulse within %0d cycles", limit);
            errors++;
        end
        @(negedge clk);
    endtask

    task automatic report_test(input int num, input string name);
        $display("Test %0d (%s) done with %0d errors", num, name, errors - test_errors);
        test_errors = errors;
    endtask

    // ------------------------------------------------
    // Response monitor
    // ------------------------------------------------
    always @(negedge clk) begin
        if (!rst && illegal) illegal_count++;
        if (!rst && resp_valid) begin
            resp_count++;
            if (exp_rd_q.size() == 0) begin
                $display("Unexpected response for rd %0d at %0t ns", resp_rd, $time);
                errors++;
            end else begin
                check_value("resp_rd_o", 32'(resp_rd), 32'(exp_rd_q.pop_front()));
                check_value("resp_rslt_o", resp_rslt, exp_rslt_q.pop_front());
            end
        end
    end

    initial begin
        logic [31:0] bad_words [3];
        int          base;
        int          quiet;
        int          cycles;
        clk = 1'b0;
        rst = 1'b1;
        req_valid = 1'b0;
        req_ir = '0;
        req_src1 = '0;
        req_src2 = '0;
        errors = 0;
        checks = 0;
        resp_count = 0;
        illegal_count = 0;
        test_errors = 0;
        seed = 32'h8e8c;
        corners = '{32'h0, 32'hffff_ffff, 32'h8000_0000, 32'h7};
        bad_words[0] = {FUNCT7_MULDIV, 10'd0, F3_MUL, 5'd3, 7'b0010011};  // OP-IMM
        bad_words[1] = {7'b0000000, 10'd0, F3_MUL, 5'd4, OPCODE_OP};      // ADD
        bad_words[2] = {7'b0100000, 10'd0, F3_DIV, 5'd5, OPCODE_OP};
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Multiply then divide group with one operation at a time
        for (int grp = 0; grp < 2; grp++) begin
            for (int f = 4 * grp; f < 4 * grp + 4; f++) begin
                for (int i = 0; i < 16; i++) begin
                    send_op(3'(f), 5'($random(seed)), corners[i / 4], corners[i % 4]);
                    wait_drain(60);
                end
                for (int i = 0; i < 6; i++) begin
                    send_op(3'(f), 5'($random(seed)), $random(seed), $random(seed));
                    wait_drain(60);
                end
            end
            report_test(grp + 1, grp ? "divide and remainder" : "multiply");
        end

        // Mixed back-to-back with at most QUEUE_DEPTH+1 outstanding
        for (int round = 0; round < 4; round++) begin
            for (int i = 0; i < QUEUE_DEPTH + 1; i++)
                send_op(3'($random(seed)), 5'($random(seed)), $random(seed), $random(seed));
            wait_drain(300);
        end
        check_value("overflow_o", 32'(overflow), 32'd0);
        report_test(3, "mixed back-to-back");

        // Divide burst overruns the queue and loses its tail
        base = resp_count;
        for (int i = 0; i < 10; i++)
            send_op({1'b1, 2'($random(seed))}, 5'(i + 1), $random(seed), $random(seed));
        check_value("overflow_o", 32'(overflow), 32'd1);
        quiet = 0;
        cycles = 0;
        while (quiet < 60 && cycles < 800) begin
            @(negedge clk);
            quiet = resp_valid ? 0 : quiet + 1;
            cycles++;
        end
        if (quiet < 60) begin
            $display("Divide burst still busy after 800 cycles");
            errors++;
        end
        if (resp_count - base < QUEUE_DEPTH + 1) begin
            $display("Only %0d burst responses arrived", resp_count - base);
            errors++;
        end
        exp_rd_q.delete();
        exp_rslt_q.delete();
        check_value("overflow_o", 32'(overflow), 32'd1);
        report_test(4, "divide burst overflow");

        // Non-M words give one pulse each and no response
        check_value("illegal_o pulses", 32'(illegal_count), 32'd0);
        for (int i = 0; i < 3; i++) begin
            base = illegal_count;
            req_valid = 1'b1;
            req_ir    = bad_words[i];
            @(negedge clk);
            req_valid = 1'b0;
            wait_illegal(base + 1, 10);
            repeat (4) @(negedge clk);
            check_value("illegal_o pulses", 32'(illegal_count), 32'(base + 1));
        end
        send_op(F3_MULHU, 5'd9, $random(seed), $random(seed));
        wait_drain(20);
        report_test(5, "illegal words");

        $display("Summary: %0d checks, %0d responses, %0d errors", checks, resp_count, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: muldiv.f
verilog/muldiv_pkg.sv
verilog/muldiv_op_if.sv
verilog/muldiv_decode.sv
verilog/muldiv_queue.sv
verilog/mul_unit.sv
verilog/div_unit.sv
verilog/muldiv_exec.sv
verilog/muldiv_top.sv
dv/muldiv_tb_asserts.sv
dv/muldiv_tb.sv

// File: Bender.yml
package:
  name: muldiv

sources:
  - verilog/muldiv_pkg.sv
  - verilog/muldiv_op_if.sv
  - verilog/muldiv_decode.sv
  - verilog/muldiv_queue.sv
  - verilog/mul_unit.sv
  - verilog/div_unit.sv
  - verilog/muldiv_exec.sv
  - verilog/muldiv_top.sv
  - target: simulation
    files:
      - dv/muldiv_tb_asserts.sv
      - dv/muldiv_tb.sv
